// File: run.sh
#!/usr/bin/env bash
# Build and run the banked scratchpad testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module banked_mem_tb \
  -f src.f \
  -o banked_mem_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/banked_mem_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Simulation passed$"; then
  exit 0
fi
exit 1

// File: src.f
+incdir+src
src/mem_req_pkg.sv
src/mem_resp_pkg.sv
src/bank_if.sv
src/stream_fifo.sv
src/mem_to_banks.sv
src/sram_bank.sv
src/banked_mem_top.sv
tb/tb_clk_gen.sv
tb/banked_mem_tb.sv

// File: src/bank_if.sv
/* Bank port bundle */
`timescale 1ns/1ns

interface bank_if
  import mem_req_pkg::*;
  import mem_resp_pkg::*;
();

  // Request handshake.
  logic        req;
  logic        gnt;
  // Request payload, byte address per bank.
  addr_t       addr;
  bank_data_t  wdata;
  bank_strb_t  strb;
  logic        we;
  // Response, one cycle after each grant.
  logic        rvalid;
  bank_rdata_t rdata;

  // Splitter side issues requests and collects responses.
  modport splitter (
    output req, addr, wdata, strb, we,
    input  gnt, rvalid, rdata
  );

  // Bank side grants and answers.
  modport bank (
    input  req, addr, wdata, strb, we,
    output gnt, rvalid, rdata
  );

endinterface

// File: src/banked_mem_top.sv
/* Banked scratchpad top */
`timescale 1ns/1ns
`include "mem_consts.svh"

module banked_mem_top
  import mem_req_pkg::*;
  import mem_resp_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  // Wide request port.
  input  logic        req_i,
  output logic        gnt_o,
  input  addr_t       addr_i,
  input  wide_data_t  wdata_i,
  input  wide_strb_t  strb_i,
  input  logic        we_i,
  // Per-bank hold-off from a competing port.
  input  bank_mask_t  bank_busy_i,
  // Wide response port.
  output logic        rvalid_o,
  output wide_rdata_t rdata_o
);

  // One bundle per bank.
  bank_if bank_bus [`MEM_NUM_BANKS] ();

  // Splits wide requests and merges bank answers.
  mem_to_banks i_splitter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .gnt_o    (gnt_o),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .strb_i   (strb_i),
    .we_i     (we_i),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .bank_o   (bank_bus)
  );

  // Bank i holds bytes 2i and 2i+1 of each wide word.
  for (genvar i = 0; i < `MEM_NUM_BANKS; i++) begin : gen_banks
    sram_bank i_bank (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .busy_i (bank_busy_i[i]),
      .port   (bank_bus[i])
    );
  end

endmodule

// File: src/mem_consts.svh
/* Scratchpad constants */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Byte address width of the wide port.
`define MEM_ADDR_WIDTH 10
// Wide port data width in bits.
`define MEM_DATA_WIDTH 64
// Number of SRAM banks behind the splitter.
`define MEM_NUM_BANKS 4
// Bank word width, one slice of the wide word.
`define MEM_BANK_WIDTH (`MEM_DATA_WIDTH / `MEM_NUM_BANKS)
// Per-bank request and response queue depth.
`define MEM_FIFO_DEPTH 2
// Outstanding wide transactions.
`define MEM_MAX_TRANS 2
// Words in each bank.
`define MEM_BANK_WORDS 128

`endif

// File: src/mem_req_pkg.sv
/* Request-side types */
`include "mem_consts.svh"

package mem_req_pkg;

  // Byte address on the wide port and on the banks.
  typedef logic [`MEM_ADDR_WIDTH-1:0]   addr_t;
  // Wide write data and byte strobes.
  typedef logic [`MEM_DATA_WIDTH-1:0]   wide_data_t;
  typedef logic [`MEM_DATA_WIDTH/8-1:0] wide_strb_t;
  // One bank's slice of data and strobes.
  typedef logic [`MEM_BANK_WIDTH-1:0]   bank_data_t;
  typedef logic [`MEM_BANK_WIDTH/8-1:0] bank_strb_t;

  // Queued request for one bank.
  typedef struct packed {
    addr_t      addr;
    bank_data_t wdata;
    bank_strb_t strb;
    logic       we;
  } bank_req_t;

  // One bit per bank, set where a write carries no strobes.
  typedef logic [`MEM_NUM_BANKS-1:0] bank_mask_t;

endpackage

// File: src/mem_resp_pkg.sv
/* Response-side types */
`include "mem_consts.svh"

package mem_resp_pkg;

  // Read word returned by one bank.
  typedef logic [`MEM_BANK_WIDTH-1:0] bank_rdata_t;

  // Wide read data, bank 0 in the lowest slice.
  typedef bank_rdata_t [`MEM_NUM_BANKS-1:0] wide_rdata_t;

endpackage

// File: src/mem_to_banks.sv
/* Wide port to bank splitter */
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_to_banks
  import mem_req_pkg::*;
  import mem_resp_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        req_i,
  output logic        gnt_o,
  input  addr_t       addr_i,
  input  wide_data_t  wdata_i,
  input  wide_strb_t  strb_i,
  input  logic        we_i,
  output logic        rvalid_o,
  output wide_rdata_t rdata_o,
  bank_if.splitter    bank_o [`MEM_NUM_BANKS]
);

  localparam int unsigned NB         = `MEM_NUM_BANKS;
  localparam int unsigned BANK_BITS  = `MEM_BANK_WIDTH;
  localparam int unsigned BANK_BYTES = `MEM_BANK_WIDTH / 8;
  localparam int unsigned WIDE_BYTES = `MEM_DATA_WIDTH / 8;

  logic       gnt_en_q;
  logic       req_push;
  addr_t      addr_aligned;
  bank_req_t  bank_in [NB];
  bank_req_t  bank_out [NB];
  bank_mask_t req_ready;
  bank_mask_t bank_valid;
  bank_mask_t bank_pop;
  bank_mask_t head_dead;
  bank_mask_t zero_strb;
  bank_mask_t dead_in;
  bank_mask_t dead_out;
  bank_mask_t dead_rsp;
  logic       dead_valid;
  logic       dead_ready;
  bank_mask_t resp_valid;
  bank_mask_t resp_ready;

  // Grants open on the first clock after reset.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gnt_en_q <= 1'b0;
    end else begin
      gnt_en_q <= 1'b1;
    end
  end

  // Accept only when every queue can take its share.
  assign gnt_o        = gnt_en_q && (&req_ready) && (&resp_ready) && dead_ready;
  assign req_push     = req_i && gnt_o;
  // Wide-word base address.
  assign addr_aligned = addr_i & ~addr_t'(WIDE_BYTES - 1);

  for (genvar i = 0; i < NB; i++) begin : gen_bank
    // Bank slice of the wide request.
    assign bank_in[i].addr  = addr_aligned + addr_t'(i * BANK_BYTES);
    assign bank_in[i].wdata = wdata_i[i*BANK_BITS +: BANK_BITS];
    assign bank_in[i].strb  = strb_i[i*BANK_BYTES +: BANK_BYTES];
    assign bank_in[i].we    = we_i;
    assign zero_strb[i]     = ~|bank_in[i].strb;

    stream_fifo #(
      .T            (bank_req_t),
      .DEPTH        (`MEM_FIFO_DEPTH),
      .FALL_THROUGH (1'b1)
    ) i_req_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (req_push),
      .ready_o (req_ready[i]),
      .data_i  (bank_in[i]),
      .valid_o (bank_valid[i]),
      .ready_i (bank_pop[i]),
      .data_o  (bank_out[i])
    );

    // A write with no strobes never reaches the bank.
    assign head_dead[i]    = bank_out[i].we && (bank_out[i].strb == '0);
    assign bank_o[i].req   = bank_valid[i] && !head_dead[i];
    assign bank_pop[i]     = head_dead[i] || bank_o[i].gnt;
    assign bank_o[i].addr  = bank_out[i].addr;
    assign bank_o[i].wdata = bank_out[i].wdata;
    assign bank_o[i].strb  = bank_out[i].strb;
    assign bank_o[i].we    = bank_out[i].we;

    // Live responses wait here for the slowest bank.
    stream_fifo #(
      .T            (bank_rdata_t),
      .DEPTH        (`MEM_FIFO_DEPTH),
      .FALL_THROUGH (1'b1)
    ) i_resp_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (bank_o[i].rvalid),
      .ready_o (resp_ready[i]),
      .data_i  (bank_o[i].rdata),
      .valid_o (resp_valid[i]),
      .ready_i (rvalid_o && !dead_rsp[i]),
      .data_o  (rdata_o[i])
    );
  end

  // Dead banks of each accepted request, in order.
  assign dead_in = {NB{we_i}} & zero_strb;

  stream_fifo #(
    .T            (bank_mask_t),
    .DEPTH        (`MEM_MAX_TRANS + 1),
    .FALL_THROUGH (1'b0)
  ) i_dead_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (req_push),
    .ready_o (dead_ready),
    .data_i  (dead_in),
    .valid_o (dead_valid),
    .ready_i (rvalid_o),
    .data_o  (dead_out)
  );

  assign dead_rsp = dead_out & {NB{dead_valid}};
  // Complete once each bank has answered or was skipped.
  assign rvalid_o = &(resp_valid | dead_rsp);

endmodule

// File: src/sram_bank.sv
/* SRAM bank */
`timescale 1ns/1ns
`include "mem_consts.svh"

module sram_bank
  import mem_req_pkg::*;
  import mem_resp_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  input  logic busy_i,
  bank_if.bank port
);

  localparam int unsigned WORD_OFFS  = $clog2(`MEM_DATA_WIDTH / 8);
  localparam int unsigned ROW_W      = $clog2(`MEM_BANK_WORDS);
  localparam int unsigned BANK_BYTES = `MEM_BANK_WIDTH / 8;

  bank_data_t  mem_q [`MEM_BANK_WORDS];
  logic [ROW_W-1:0] row;
  logic        granted;
  logic        rvalid_q;
  bank_rdata_t rdata_q;

  // A competing port holds the bank off.
  assign port.gnt = !busy_i;
  assign granted  = port.req && port.gnt;
  // Row index sits above the wide-word byte offset.
  assign row      = port.addr[WORD_OFFS +: ROW_W];

  // Byte-strobed write.
  always_ff @(posedge clk_i) begin
    if (granted && port.we) begin
      for (int b = 0; b < BANK_BYTES; b++) begin
        if (port.strb[b]) begin
          mem_q[row][b*8 +: 8] <= port.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Old row contents, returned for reads and writes alike.
  always_ff @(posedge clk_i) begin
    if (granted) begin
      rdata_q <= mem_q[row];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= granted;
    end
  end

  assign port.rvalid = rvalid_q;
  assign port.rdata  = rdata_q;

endmodule

// File: src/stream_fifo.sv
/* Valid/ready FIFO */
`timescale 1ns/1ns

module stream_fifo #(
  parameter type         T            = logic,
  parameter int unsigned DEPTH        = 2,
  parameter bit          FALL_THROUGH = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             empty;
  logic             bypass;
  logic             push;
  logic             pop;

  // Circular pointer step.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty   = (count_q == '0);
  assign ready_o = (count_q < CNT_W'(DEPTH));
  // An empty queue in fall-through mode hands its input straight on.
  assign bypass  = FALL_THROUGH && empty;
  assign valid_o = bypass ? valid_i : !empty;
  assign data_o  = bypass ? data_i : mem_q[rd_ptr_q];
  // A bypassed word taken in the same cycle is never stored.
  assign push    = valid_i && ready_o && !(bypass && ready_i);
  assign pop     = !empty && ready_i;

  // Pointers and fill level.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Payload storage.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: tb/banked_mem_tb.sv
/* Banked scratchpad testbench */
`timescale 1ns/1ns
`include "mem_consts.svh"

module banked_mem_tb
  import mem_req_pkg::*;
  import mem_resp_pkg::*;
();

  localparam int unsigned WORDS      = `MEM_BANK_WORDS;
  localparam int unsigned WORD_OFFS  = $clog2(`MEM_DATA_WIDTH / 8);
  localparam int unsigned NUM_RANDOM = 400;
  // Fill, latency, strobe, busy-burst and random requests.
  localparam int unsigned NUM_TRANS  = WORDS + 1 + 4 + 6 + NUM_RANDOM;
  localparam longint      TIMEOUT_NS = (longint'(NUM_TRANS) * 64 + 200) * 8;
  localparam int unsigned DRAIN_MAX  = 200;

  logic        clk_i;
  logic        rst_i;
  logic        req_i;
  logic        gnt_o;
  addr_t       addr_i;
  wide_data_t  wdata_i;
  wide_strb_t  strb_i;
  logic        we_i;
  bank_mask_t  bank_busy_i;
  logic        rvalid_o;
  wide_rdata_t rdata_o;

  // Reference memory and expected responses in acceptance order.
  wide_data_t  model_mem [WORDS];
  bit          exp_read [$];
  wide_rdata_t exp_data [$];
  // 0 idle banks, 1 random busy, 2 bank 2 held busy.
  int          busy_mode;
  bit          stall_seen;

  tb_clk_gen #(.PERIOD_NS(8)) i_clk (.clk_o(clk_i));

  banked_mem_top dut0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .gnt_o       (gnt_o),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .strb_i      (strb_i),
    .we_i        (we_i),
    .bank_busy_i (bank_busy_i),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o)
  );

  task automatic fail_run(input string why);
    $display("%0t ns: %s", $time, why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_rdata(input string name, input wide_rdata_t exp, input wide_rdata_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Initial word contents that differ for every address.
  function automatic wide_data_t fill_pattern(input int unsigned w);
    return {4{8'(w) ^ 8'h3c, 8'(w)}};
  endfunction

  // Model update and expected response for an accepted request.
  task automatic record_accept(input logic we, input addr_t addr, input wide_data_t wdata,
                               input wide_strb_t strb);
    int unsigned w;
    w = int'(addr >> WORD_OFFS);
    if (we) begin
      for (int b = 0; b < `MEM_DATA_WIDTH / 8; b++) begin
        if (strb[b]) begin
          model_mem[w][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
      exp_read.push_back(1'b0);
      exp_data.push_back('0);
    end else begin
      exp_read.push_back(1'b1);
      exp_data.push_back(model_mem[w]);
    end
  endtask

  // Holds the request until granted and records it 1 ns after the grant edge.
  task automatic issue_req(input logic we, input addr_t addr, input wide_data_t wdata,
                           input wide_strb_t strb);
    bit granted;
    granted = 1'b0;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    strb_i  = strb;
    while (!granted) begin
      @(negedge clk_i);
      granted = gnt_o;
      @(posedge clk_i);
      #1;
    end
    record_accept(we, addr, wdata, strb);
    req_i  = 1'b0;
    we_i   = 1'b0;
    strb_i = '0;
  endtask

  task automatic wait_idle();
    while (exp_read.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    #1;
  endtask

  // Response monitor sampling mid-cycle.
  always @(negedge clk_i) begin : resp_monitor
    bit          is_read;
    wide_rdata_t exp;
    if (!rst_i && rvalid_o) begin
      if (exp_read.size() == 0) begin
        fail_run("rvalid_o pulsed with no request outstanding");
      end else begin
        is_read = exp_read.pop_front();
        exp     = exp_data.pop_front();
        if (is_read) begin
          check_rdata("rdata_o", exp, rdata_o);
        end
      end
    end
    if (!rst_i && req_i && !gnt_o) begin
      stall_seen = 1'b1;
    end
  end

  // Bank hold-off pattern driven just after each edge.
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      case (busy_mode)
        1:       bank_busy_i = bank_mask_t'($urandom) & bank_mask_t'($urandom)
                               & bank_mask_t'($urandom);
        2:       bank_busy_i = 4'b0100;
        default: bank_busy_i = '0;
      endcase
    end
  end

  // Watchdog.
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin
    int unsigned drain;
    void'($urandom(32'hab87_5f4b));
    rst_i       = 1'b1;
    req_i       = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    strb_i      = '0;
    we_i        = 1'b0;
    bank_busy_i = '0;
    busy_mode   = 0;
    stall_seen  = 1'b0;
    drain       = 0;

    // Outputs stay quiet through reset and the first cycle after it.
    repeat (10) begin
      @(negedge clk_i);
      check_level("gnt_o", 1'b0, gnt_o);
      check_level("rvalid_o", 1'b0, rvalid_o);
    end
    @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_level("gnt_o", 1'b0, gnt_o);
    check_level("rvalid_o", 1'b0, rvalid_o);
    @(negedge clk_i);
    check_level("gnt_o", 1'b1, gnt_o);
    @(posedge clk_i);
    #1;

    // Fill every word so later reads are defined.
    for (int unsigned w = 0; w < WORDS; w++) begin
      issue_req(1'b1, addr_t'(w << WORD_OFFS), fill_pattern(w), '1);
    end
    wait_idle();

    // Idle read answers in the next cycle.
    issue_req(1'b0, addr_t'(17 << WORD_OFFS), '0, '0);
    @(negedge clk_i);
    check_level("rvalid_o", 1'b1, rvalid_o);
    @(posedge clk_i);
    #1;

    // Partial merge, fully dead write, then dead banks 1 and 2.
    issue_req(1'b1, addr_t'(5 << WORD_OFFS), 64'h1122_3344_5566_7788, 8'b0000_0101);
    issue_req(1'b1, addr_t'(5 << WORD_OFFS), 64'hdead_beef_dead_beef, 8'h00);
    issue_req(1'b1, addr_t'(5 << WORD_OFFS) + 3, 64'h99aa_bbcc_ddee_ff00, 8'b1000_0010);
    issue_req(1'b0, addr_t'(5 << WORD_OFFS), '0, '0);
    wait_idle();

    // Long busy burst on bank 2 must stall the wide port.
    stall_seen = 1'b0;
    busy_mode  = 2;
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          issue_req(i[0], addr_t'($urandom_range(WORDS - 1) << WORD_OFFS),
                    {$urandom, $urandom}, wide_strb_t'($urandom));
        end
      end
      begin
        repeat (48) @(posedge clk_i);
        #1;
        busy_mode = 0;
      end
    join
    if (!stall_seen) begin
      fail_run("gnt_o never dropped while bank 2 was held busy");
    end
    wait_idle();

    // Random traffic under random bank hold-off.
    busy_mode = 1;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      int unsigned kind;
      kind = $urandom_range(3);
      issue_req(logic'($urandom_range(1)),
                addr_t'(($urandom_range(WORDS - 1) << WORD_OFFS) | $urandom_range(7)),
                {$urandom, $urandom},
                (kind == 0) ? wide_strb_t'(0) :
                (kind == 1) ? wide_strb_t'(8'hff) : wide_strb_t'($urandom));
      if ($urandom_range(3) == 0) begin
        @(posedge clk_i);
        #1;
      end
    end
    busy_mode = 0;

    // Wait for the last responses, bounded.
    while (exp_read.size() != 0 && drain < DRAIN_MAX) begin
      @(negedge clk_i);
      drain++;
    end
    // A few quiet cycles catch stray pulses.
    repeat (4) @(negedge clk_i);

    if (exp_read.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_run("responses still missing after the last request");
    end
  end

endmodule

// File: tb/tb_clk_gen.sv
/* Testbench clock */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS = 8
) (
  output logic clk_o
);

  // Free-running clock, low at time zero.
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule
